// ==== rv_frontend.f ====
+incdir+hw
hw/rv_isa_pkg.sv
hw/rv_core_pkg.sv
hw/instruction_decoder.sv
hw/register_file.sv
hw/jump_branch_unit.sv
hw/fetch_unit.sv
hw/rv_frontend.sv
verification/tb_rv_frontend.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build with Verilator and run; exit status follows the simulation

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    --top-module tb_rv_frontend \
    -f rv_frontend.f \
    -o sim_rv_frontend \
    && ./obj_dir/sim_rv_frontend \
    || { echo "Build or simulation returned an error" >&2; exit 1; }

// ==== verification/tb_rv_frontend.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_frontend_macros.svh"

module tb_rv_frontend;

    localparam int N_RAND = 40;

    typedef struct packed {
        logic [31:0] rs1_val;
        logic [31:0] rs2_val;
        logic [31:0] instr;
        logic        exp_redirect;
        logic        exp_link;
        logic        exp_abs;   // exp_next is an absolute target
        logic [31:0] exp_next;  // Offset from pc otherwise
    } row_t;

    logic                  clk;
    logic                  arst_n;
    logic                  instr_valid;
    rv_isa_pkg::instr_t    instr;
    logic                  wb_en;
    rv_core_pkg::reg_idx_t wb_rd;
    rv_core_pkg::word_t    wb_data;
    rv_core_pkg::pc_t      pc;
    logic                  redirect;
    logic                  link_valid;
    rv_core_pkg::reg_idx_t link_rd;
    rv_core_pkg::word_t    link_data;

    row_t             rows[$];
    rv_core_pkg::pc_t exp_pc;
    logic [31:0]      rng;
    int               cycles;
    int               cycle_limit;

    rv_frontend DUT (
        .clk         (clk),
        .arst_n      (arst_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .wb_en       (wb_en),
        .wb_rd       (wb_rd),
        .wb_data     (wb_data),
        .pc          (pc),
        .redirect    (redirect),
        .link_valid  (link_valid),
        .link_rd     (link_rd),
        .link_data   (link_data)
    );

    always #2 clk = ~clk;

    initial begin
        cycles = 0;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > cycle_limit) begin
            $display("Timeout: no result after %0d clock cycles", cycle_limit);
            $display("SIMULATION FAILED");
            $fatal(1, "cycle limit reached");
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Reference branch rule from the funct3 codes
    function automatic logic branch_taken(input logic [2:0] f3, input logic [31:0] a,
                                          input logic [31:0] b);
        case (f3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return $signed(a) < $signed(b);
            3'b101:  return $signed(a) >= $signed(b);
            3'b110:  return a < b;
            3'b111:  return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    function automatic rv_isa_pkg::instr_t enc_b(input logic [2:0] f3, input logic [4:0] rs1,
                                                 input logic [4:0] rs2, input logic [31:0] imm);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], rv_isa_pkg::OPC_BRANCH};
    endfunction

    function automatic rv_isa_pkg::instr_t enc_j(input logic [4:0] rd, input logic [31:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rv_isa_pkg::OPC_JAL};
    endfunction

    function automatic rv_isa_pkg::instr_t enc_i(input rv_isa_pkg::opcode_e opc,
                                                 input logic [2:0] f3, input logic [4:0] rd,
                                                 input logic [4:0] rs1, input logic [31:0] imm);
        return {imm[11:0], rs1, f3, rd, opc};
    endfunction

    function automatic rv_isa_pkg::instr_t enc_r(input logic [2:0] f3, input logic [4:0] rd,
                                                 input logic [4:0] rs1, input logic [4:0] rs2);
        return {7'b0, rs2, rs1, f3, rd, rv_isa_pkg::OPC_OP};
    endfunction

    task automatic report_mismatch(input string what, input logic [31:0] exp,
                                   input logic [31:0] got);
        $display("[ERROR] %0t: %s expected %h, got %h", $time, what, exp, got);
        $display("SIMULATION FAILED");
        $fatal(1, "output mismatch");
    endtask

    task automatic check_pc(input rv_core_pkg::pc_t got, input rv_core_pkg::pc_t exp,
                            input string what);
        if (got !== exp) begin
            report_mismatch(what, exp, got);
        end
    endtask

    task automatic check_word(input rv_core_pkg::word_t got, input rv_core_pkg::word_t exp,
                              input string what);
        if (got !== exp) begin
            report_mismatch(what, exp, got);
        end
    endtask

    task automatic check_idx(input rv_core_pkg::reg_idx_t got, input rv_core_pkg::reg_idx_t exp,
                             input string what);
        if (got !== exp) begin
            report_mismatch(what, {27'b0, exp}, {27'b0, got});
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            report_mismatch(what, {31'b0, exp}, {31'b0, got});
        end
    endtask

    task automatic add_row(input logic [31:0] a, input logic [31:0] b,
                           input rv_isa_pkg::instr_t word, input logic red, input logic link,
                           input logic abs_tgt, input logic [31:0] next);
        row_t r;
        r.rs1_val      = a;
        r.rs2_val      = b;
        r.instr        = word;
        r.exp_redirect = red;
        r.exp_link     = link;
        r.exp_abs      = abs_tgt;
        r.exp_next     = next;
        rows.push_back(r);
    endtask

    task automatic load_table();
        add_row(32'd5, 32'd5, enc_b(3'b000, 5'd1, 5'd2, 32'd16), 1'b1, 1'b0, 1'b0, 32'd16);
        add_row(32'd5, 32'd6, enc_b(3'b000, 5'd1, 5'd2, 32'd16), 1'b0, 1'b0, 1'b0, 32'd4);
        add_row(32'd7, 32'd8, enc_b(3'b001, 5'd3, 5'd4, -32'sd8), 1'b1, 1'b0, 1'b0, -32'sd8);
        add_row(32'd7, 32'd7, enc_b(3'b001, 5'd3, 5'd4, -32'sd8), 1'b0, 1'b0, 1'b0, 32'd4);
        add_row(32'hFFFF_FFFF, 32'd1, enc_b(3'b100, 5'd1, 5'd2, 32'd32), 1'b1, 1'b0, 1'b0, 32'd32);
        add_row(32'd1, 32'hFFFF_FFFF, enc_b(3'b100, 5'd1, 5'd2, 32'd32), 1'b0, 1'b0, 1'b0, 32'd4);
        add_row(32'hFFFF_FFFF, 32'd1, enc_b(3'b101, 5'd8, 5'd9, 32'd20), 1'b0, 1'b0, 1'b0, 32'd4);
        add_row(32'd3, 32'd3, enc_b(3'b101, 5'd8, 5'd9, 32'd20), 1'b1, 1'b0, 1'b0, 32'd20);
        add_row(32'hFFFF_FFFF, 32'd1, enc_b(3'b110, 5'd1, 5'd2, -32'sd12), 1'b0, 1'b0, 1'b0, 32'd4);
        add_row(32'd1, 32'hFFFF_FFFF, enc_b(3'b110, 5'd1, 5'd2, -32'sd12),
                1'b1, 1'b0, 1'b0, -32'sd12);
        add_row(32'hFFFF_FFFF, 32'd1, enc_b(3'b111, 5'd1, 5'd2, 32'd12), 1'b1, 1'b0, 1'b0, 32'd12);
        add_row(32'd2, 32'd3, enc_b(3'b111, 5'd1, 5'd2, 32'd12), 1'b0, 1'b0, 1'b0, 32'd4);
        add_row(32'd0, 32'd0, enc_j(5'd10, 32'd64), 1'b1, 1'b1, 1'b0, 32'd64);
        add_row(32'd0, 32'd0, enc_j(5'd12, -32'sd2048), 1'b1, 1'b1, 1'b0, -32'sd2048);
        // rs1 + imm is odd, bit 0 dropped
        add_row(32'h102, 32'd0, enc_i(rv_isa_pkg::OPC_JALR, 3'b000, 5'd11, 5'd5, 32'd3),
                1'b1, 1'b1, 1'b1, 32'h104);
        add_row(32'h400, 32'd0, enc_i(rv_isa_pkg::OPC_JALR, 3'b000, 5'd1, 5'd7, -32'sd7),
                1'b1, 1'b1, 1'b1, 32'h3F8);
        add_row(32'd9, 32'd9, enc_r(3'b000, 5'd3, 5'd1, 5'd2), 1'b0, 1'b0, 1'b0, 32'd4);
        add_row(32'd9, 32'd9, enc_i(rv_isa_pkg::OPC_LOAD, 3'b010, 5'd1, 5'd2, 32'd4),
                1'b0, 1'b0, 1'b0, 32'd4);
        add_row(32'd4, 32'd4, enc_b(3'b010, 5'd1, 5'd2, 32'd16), 1'b0, 1'b0, 1'b0, 32'd4);
        add_row(32'd4, 32'd4, enc_b(3'b011, 5'd1, 5'd2, 32'd16), 1'b0, 1'b0, 1'b0, 32'd4);
        add_row(32'h55, 32'hAA, enc_b(3'b000, 5'd0, 5'd0, 32'd8), 1'b1, 1'b0, 1'b0, 32'd8);
        // Write to x0 dropped, so x0 still equals the zero in x7
        add_row(32'h55, 32'd0, enc_b(3'b001, 5'd0, 5'd7, 32'd8), 1'b0, 1'b0, 1'b0, 32'd4);
    endtask

    task automatic write_reg(input rv_core_pkg::reg_idx_t idx, input rv_core_pkg::word_t val);
        @(posedge clk);
        #1;
        instr_valid = 1'b0;
        wb_en       = 1'b1;
        wb_rd       = idx;
        wb_data     = val;
    endtask

    task automatic run_row(input row_t r);
        rv_core_pkg::pc_t next_exp;
        write_reg(r.instr[19:15], r.rs1_val);
        write_reg(r.instr[24:20], r.rs2_val);
        @(posedge clk);
        #1;
        wb_en       = 1'b0;
        instr       = r.instr;
        instr_valid = 1'b1;
        @(negedge clk);
        check_bit(redirect, r.exp_redirect, "redirect");
        check_bit(link_valid, r.exp_link, "link_valid");
        if (r.exp_link) begin
            check_idx(link_rd, r.instr[11:7], "link_rd");
            check_word(link_data, exp_pc + 32'd4, "link_data");
        end
        next_exp = r.exp_abs ? r.exp_next : exp_pc + r.exp_next;
        @(posedge clk);
        #1;
        instr_valid = 1'b0;
        @(negedge clk);
        check_pc(pc, next_exp, "pc after instruction");
        exp_pc = next_exp;
    endtask

    initial begin
        row_t        r;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] sel;
        logic [31:0] imm;
        logic        taken;
        clk         = 1'b0;
        arst_n      = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        wb_en       = 1'b0;
        wb_rd       = '0;
        wb_data     = '0;
        rng         = 32'h634f2f2d;
        exp_pc      = `RV_RESET_PC;
        load_table();
        cycle_limit = rows.size() * 6 + N_RAND * 6 + 50;

        repeat (3) @(posedge clk);
        @(negedge clk);
        check_pc(pc, `RV_RESET_PC, "pc in reset");
        check_bit(redirect, 1'b0, "redirect in reset");
        check_bit(link_valid, 1'b0, "link_valid in reset");
        @(posedge clk);
        #1;
        arst_n = 1'b1;
        instr  = enc_j(5'd1, 32'd64);  // Jump present but not valid

        repeat (3) begin
            @(negedge clk);
            check_pc(pc, exp_pc, "pc while stalled");
            check_bit(redirect, 1'b0, "redirect while stalled");
            check_bit(link_valid, 1'b0, "link_valid while stalled");
        end

        for (int i = 0; i < rows.size(); i++) begin
            run_row(rows[i]);
        end

        // Random branches on x5 and x6
        for (int n = 0; n < N_RAND; n++) begin
            rng = xorshift32(rng);
            a   = rng;
            rng = xorshift32(rng);
            sel = rng;
            case (sel[1:0])
                2'd0: b = a;
                2'd1: b = ~a;  // Opposite sign
                default: begin
                    rng = xorshift32(rng);
                    b   = rng;
                end
            endcase
            imm   = {{19{sel[20]}}, sel[20:10], 2'b00};
            taken = branch_taken(sel[4:2], a, b);
            r.rs1_val      = a;
            r.rs2_val      = b;
            r.instr        = enc_b(sel[4:2], 5'd5, 5'd6, imm);
            r.exp_redirect = taken;
            r.exp_link     = 1'b0;
            r.exp_abs      = 1'b0;
            r.exp_next     = taken ? imm : 32'd4;
            run_row(r);
        end

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== hw/rv_frontend.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_frontend (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  instr_valid,
    input  rv_isa_pkg::instr_t    instr,
    input  logic                  wb_en,
    input  rv_core_pkg::reg_idx_t wb_rd,
    input  rv_core_pkg::word_t    wb_data,
    output rv_core_pkg::pc_t      pc,
    output logic                  redirect,
    output logic                  link_valid,
    output rv_core_pkg::reg_idx_t link_rd,
    output rv_core_pkg::word_t    link_data
);

    rv_isa_pkg::opcode_e     opcode;
    rv_isa_pkg::instr_type_e instr_type;
    logic [2:0]              funct3;
    rv_core_pkg::reg_idx_t   rs1_idx;
    rv_core_pkg::reg_idx_t   rs2_idx;
    rv_core_pkg::word_t      imm;
    rv_core_pkg::word_t      rs1_data;
    rv_core_pkg::word_t      rs2_data;
    rv_core_pkg::pc_t        target;

    instruction_decoder u_decoder (
        .instr      (instr),
        .opcode     (opcode),
        .instr_type (instr_type),
        .funct3     (funct3),
        .rd_idx     (link_rd),  // Link destination is rd
        .rs1_idx    (rs1_idx),
        .rs2_idx    (rs2_idx),
        .imm        (imm)
    );

    register_file u_regfile (
        .clk      (clk),
        .arst_n   (arst_n),
        .rs1_idx  (rs1_idx),
        .rs2_idx  (rs2_idx),
        .wb_en    (wb_en),
        .wb_rd    (wb_rd),
        .wb_data  (wb_data),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    jump_branch_unit u_jbu (
        .instr_valid        (instr_valid),
        .opcode             (opcode),
        .funct3             (funct3),
        .instr_type         (instr_type),
        .rs1_data           (rs1_data),
        .rs2_data           (rs2_data),
        .pc                 (pc),
        .imm                (imm),
        .jump_branch_enable (redirect),
        .target             (target),
        .link_valid         (link_valid),
        .link_data          (link_data)
    );

    fetch_unit u_fetch (
        .clk                (clk),
        .arst_n             (arst_n),
        .instr_valid        (instr_valid),
        .jump_branch_enable (redirect),
        .target             (target),
        .pc                 (pc)
    );

endmodule

`default_nettype wire

// ==== hw/fetch_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_frontend_macros.svh"

module fetch_unit (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             instr_valid,
    input  logic             jump_branch_enable,
    input  rv_core_pkg::pc_t target,
    output rv_core_pkg::pc_t pc
);

    rv_core_pkg::pc_t pc_plus4;
    rv_core_pkg::pc_t next_pc;

    assign pc_plus4 = pc + 32'd4;

    always_comb begin
        if (!instr_valid) begin
            next_pc = pc;  // Stall
        end else if (jump_branch_enable) begin
            next_pc = target;
        end else begin
            next_pc = pc_plus4;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc <= `RV_RESET_PC;
        end else begin
            pc <= next_pc;
        end
    end

    // No compressed support, so every fetch address is a full word
    a_pc_aligned: assert property (
        @(posedge clk) disable iff (!arst_n)
        pc[1:0] == 2'b00
    ) else $error("fetch_unit: pc not word aligned");

endmodule

`default_nettype wire

// ==== hw/jump_branch_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module jump_branch_unit (
    input  logic                    instr_valid,
    input  rv_isa_pkg::opcode_e     opcode,
    input  logic [2:0]              funct3,
    input  rv_isa_pkg::instr_type_e instr_type,
    input  rv_core_pkg::word_t      rs1_data,
    input  rv_core_pkg::word_t      rs2_data,
    input  rv_core_pkg::pc_t        pc,
    input  rv_core_pkg::word_t      imm,
    output logic                    jump_branch_enable,
    output rv_core_pkg::pc_t        target,
    output logic                    link_valid,
    output rv_core_pkg::word_t      link_data
);

    rv_core_pkg::branch_kind_e branch_kind;
    logic                      cond_true;
    logic                      taken;
    rv_core_pkg::word_t        jalr_sum;
    rv_core_pkg::pc_t          raw_target;

    always_comb begin
        if (opcode == rv_isa_pkg::OPC_JALR) begin
            branch_kind = rv_core_pkg::BK_JALR;
        end else if (instr_type == rv_isa_pkg::TYPE_J) begin
            branch_kind = rv_core_pkg::BK_JAL;
        end else if (instr_type == rv_isa_pkg::TYPE_B && opcode == rv_isa_pkg::OPC_BRANCH) begin
            branch_kind = rv_core_pkg::BK_COND;
        end else begin
            branch_kind = rv_core_pkg::BK_NONE;
        end
    end

    always_comb begin
        case (funct3)
            rv_isa_pkg::F3_BEQ:  cond_true = (rs1_data == rs2_data);
            rv_isa_pkg::F3_BNE:  cond_true = (rs1_data != rs2_data);
            rv_isa_pkg::F3_BLT:  cond_true = ($signed(rs1_data) <  $signed(rs2_data));
            rv_isa_pkg::F3_BGE:  cond_true = ($signed(rs1_data) >= $signed(rs2_data));
            rv_isa_pkg::F3_BLTU: cond_true = (rs1_data <  rs2_data);
            rv_isa_pkg::F3_BGEU: cond_true = (rs1_data >= rs2_data);
            default:             cond_true = 1'b0;  // 010, 011 never taken
        endcase
    end

    // Jumps are unconditional
    assign taken = (branch_kind == rv_core_pkg::BK_JAL)
                || (branch_kind == rv_core_pkg::BK_JALR)
                || ((branch_kind == rv_core_pkg::BK_COND) && cond_true);

    assign jalr_sum = rs1_data + imm;

    always_comb begin
        if (branch_kind == rv_core_pkg::BK_JALR) begin
            raw_target = {jalr_sum[31:1], 1'b0};
        end else begin
            raw_target = pc + imm;
        end
    end

    assign jump_branch_enable = instr_valid && taken;
    assign target             = instr_valid ? raw_target : '0;
    assign link_valid         = instr_valid && ((branch_kind == rv_core_pkg::BK_JAL)
                                             || (branch_kind == rv_core_pkg::BK_JALR));
    assign link_data          = instr_valid ? (pc + 32'd4) : '0;  // Return address

    // Settled value only, the path from the fetch PC ripples through here
    always_comb begin
        if (jump_branch_enable) begin
            a_target_aligned: assert final (target[1:0] == 2'b00)
                else $error("jump_branch_unit: taken target not word aligned");
        end
    end

endmodule

`default_nettype wire

// ==== hw/register_file.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_frontend_macros.svh"

module register_file (
    input  logic                  clk,
    input  logic                  arst_n,
    input  rv_core_pkg::reg_idx_t rs1_idx,
    input  rv_core_pkg::reg_idx_t rs2_idx,
    input  logic                  wb_en,
    input  rv_core_pkg::reg_idx_t wb_rd,
    input  rv_core_pkg::word_t    wb_data,
    output rv_core_pkg::word_t    rs1_data,
    output rv_core_pkg::word_t    rs2_data
);

    rv_core_pkg::word_t regs [`RV_NUM_REGS];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `RV_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_en && (wb_rd != '0)) begin  // x0 stays zero
            regs[wb_rd] <= wb_data;
        end
    end

    // Asynchronous read, so a same-cycle write is seen one cycle later
    assign rs1_data = regs[rs1_idx];
    assign rs2_data = regs[rs2_idx];

    // x0 reads as zero on both ports
    a_x0_reads_zero: assert property (
        @(posedge clk) disable iff (!arst_n)
        ((rs1_idx == '0) |-> (rs1_data == '0)) and ((rs2_idx == '0) |-> (rs2_data == '0))
    ) else $error("register_file: x0 read returned nonzero");

endmodule

`default_nettype wire

// ==== hw/instruction_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module instruction_decoder (
    input  rv_isa_pkg::instr_t      instr,
    output rv_isa_pkg::opcode_e     opcode,
    output rv_isa_pkg::instr_type_e instr_type,
    output logic [2:0]              funct3,
    output rv_core_pkg::reg_idx_t   rd_idx,
    output rv_core_pkg::reg_idx_t   rs1_idx,
    output rv_core_pkg::reg_idx_t   rs2_idx,
    output rv_core_pkg::word_t      imm
);

    rv_core_pkg::word_t imm_i;
    rv_core_pkg::word_t imm_s;
    rv_core_pkg::word_t imm_b;
    rv_core_pkg::word_t imm_u;
    rv_core_pkg::word_t imm_j;

    // Fixed field positions, valid or not for the format
    assign opcode  = rv_isa_pkg::opcode_e'(instr[6:0]);
    assign rd_idx  = instr[11:7];
    assign funct3  = instr[14:12];
    assign rs1_idx = instr[19:15];
    assign rs2_idx = instr[24:20];

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        case (opcode)
            rv_isa_pkg::OPC_BRANCH: begin
                instr_type = rv_isa_pkg::TYPE_B;
            end
            rv_isa_pkg::OPC_JAL: begin
                instr_type = rv_isa_pkg::TYPE_J;
            end
            rv_isa_pkg::OPC_JALR,
            rv_isa_pkg::OPC_OP_IMM,
            rv_isa_pkg::OPC_LOAD: begin
                instr_type = rv_isa_pkg::TYPE_I;
            end
            rv_isa_pkg::OPC_STORE: begin
                instr_type = rv_isa_pkg::TYPE_S;
            end
            rv_isa_pkg::OPC_LUI,
            rv_isa_pkg::OPC_AUIPC: begin
                instr_type = rv_isa_pkg::TYPE_U;
            end
            rv_isa_pkg::OPC_OP: begin
                instr_type = rv_isa_pkg::TYPE_R;
            end
            default: begin
                instr_type = rv_isa_pkg::TYPE_NONE;
            end
        endcase
    end

    always_comb begin
        case (instr_type)
            rv_isa_pkg::TYPE_I: begin
                imm = imm_i;
            end
            rv_isa_pkg::TYPE_S: begin
                imm = imm_s;
            end
            rv_isa_pkg::TYPE_B: begin
                imm = imm_b;
            end
            rv_isa_pkg::TYPE_U: begin
                imm = imm_u;
            end
            rv_isa_pkg::TYPE_J: begin
                imm = imm_j;
            end
            default: begin
                imm = '0;  // R-type and unknown
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== hw/rv_core_pkg.sv ====
`default_nettype none

`include "rv_frontend_macros.svh"

package rv_core_pkg;

    typedef logic [`RV_XLEN-1:0] word_t;

    typedef logic [31:0] pc_t;

    typedef logic [4:0] reg_idx_t;

    // Control transfer class of the current word
    typedef enum logic [1:0] {
        BK_NONE = 2'd0,
        BK_COND = 2'd1,
        BK_JAL  = 2'd2,
        BK_JALR = 2'd3
    } branch_kind_e;

endpackage

`default_nettype wire

// ==== hw/rv_isa_pkg.sv ====
`default_nettype none

package rv_isa_pkg;

    typedef logic [31:0] instr_t;

    // Major opcodes, instr[6:0]
    typedef enum logic [6:0] {
        OPC_LOAD   = 7'b0000011,
        OPC_OP_IMM = 7'b0010011,
        OPC_AUIPC  = 7'b0010111,
        OPC_STORE  = 7'b0100011,
        OPC_OP     = 7'b0110011,
        OPC_LUI    = 7'b0110111,
        OPC_BRANCH = 7'b1100011,
        OPC_JALR   = 7'b1100111,
        OPC_JAL    = 7'b1101111
    } opcode_e;

    // Numbering kept from the branch unit's format codes
    typedef enum logic [2:0] {
        TYPE_I    = 3'd0,
        TYPE_B    = 3'd1,
        TYPE_S    = 3'd2,
        TYPE_U    = 3'd3,
        TYPE_J    = 3'd4,
        TYPE_R    = 3'd6,
        TYPE_NONE = 3'd7  // Unknown opcode
    } instr_type_e;

    // funct3 of BRANCH words
    typedef enum logic [2:0] {
        F3_BEQ  = 3'b000,
        F3_BNE  = 3'b001,
        F3_BLT  = 3'b100,
        F3_BGE  = 3'b101,
        F3_BLTU = 3'b110,
        F3_BGEU = 3'b111
    } branch_funct3_e;

endpackage

`default_nettype wire

// ==== hw/rv_frontend_macros.svh ====
`ifndef RV_FRONTEND_MACROS_SVH
`define RV_FRONTEND_MACROS_SVH

// Datapath width
`define RV_XLEN 32

// Fetch starts here
`define RV_RESET_PC 32'h0000_0000

// Architectural integer registers
`define RV_NUM_REGS 32

`endif
